// File: ppu_cfg.svh
`ifndef PPU_CFG_SVH
`define PPU_CFG_SVH

// Visible screen size in pixels
`define SCREEN_W 160
`define SCREEN_H 144

// Dots per line and lines per frame, VBlank included
`define LINE_DOTS 456
`define FRAME_LINES 154

// OAM scan length in dots, drawing starts right after
`define MODE2_DOTS 80

// VRAM is 8 KiB, byte addressed from 0x8000
`define VRAM_AW 13

`endif

// File: ppu_pkg.sv
`include "ppu_cfg.svh"

package ppu_pkg;

  // PPU modes, encoded as on the real hardware
  typedef enum logic [1:0] {
    MODE_HBLANK,
    MODE_VBLANK,
    MODE_OAM,
    MODE_DRAW
  } ppu_mode_t;

  // Host register write opcode
  typedef enum logic [2:0] {
    REG_LCDC,
    REG_SCY,
    REG_SCX,
    REG_WY,
    REG_WX
  } reg_sel_t;

  // Background fetcher steps
  typedef enum logic [1:0] {
    FETCH_TILE,
    FETCH_LOW,
    FETCH_HIGH,
    FETCH_PUSH
  } fetch_state_t;

  typedef struct packed {
    logic [7:0] lcdc;
    logic [7:0] scy;
    logic [7:0] scx;
    logic [7:0] wy;
    logic [7:0] wx;
  } ppu_regs_t;

  typedef struct packed {
    reg_sel_t   sel;
    logic [7:0] data;
  } reg_wr_t;

  // Address is the offset from 0x8000
  typedef struct packed {
    logic [`VRAM_AW-1:0] addr;
    logic [7:0]          data;
  } vram_wr_t;

  typedef struct packed {
    ppu_mode_t  mode;
    logic [7:0] ly;
    logic       line_start;
    logic       frame_start;
  } ppu_time_t;

  typedef struct packed {
    logic [1:0] color;
    logic [7:0] x;
    logic [7:0] y;
  } pixel_t;

  // One row of a tile, two bit planes
  typedef struct packed {
    logic [7:0] low;
    logic [7:0] high;
  } tile_row_t;

endpackage

// File: ppu_regs.sv
module ppu_regs (
  input  logic               clk,
  input  logic               reset,
  input  logic               reg_wr_valid,
  input  ppu_pkg::reg_wr_t   reg_wr,
  output ppu_pkg::ppu_regs_t regs
);
  import ppu_pkg::*;

  // Current register set, seen by timing and fetcher
  ppu_regs_t regs_q;

  // Writes are always accepted and land on the next edge
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regs_q <= '0;
    end else if (reg_wr_valid) begin
      // Opcode picks which byte gets the data
      case (reg_wr.sel)
        REG_LCDC: begin
          regs_q.lcdc <= reg_wr.data;
        end
        REG_SCY: begin
          regs_q.scy <= reg_wr.data;
        end
        REG_SCX: begin
          // Only bits 7:3 matter downstream, whole tiles
          regs_q.scx <= reg_wr.data;
        end
        REG_WY: begin
          regs_q.wy <= reg_wr.data;
        end
        REG_WX: begin
          regs_q.wx <= reg_wr.data;
        end
        default: begin
          // Unused opcodes are ignored
          regs_q <= regs_q;
        end
      endcase
    end
  end

  assign regs = regs_q;

endmodule

// File: ppu_timing.sv
`include "ppu_cfg.svh"

module ppu_timing (
  input  logic               clk,
  input  logic               reset,
  input  ppu_pkg::ppu_regs_t regs,
  input  logic               line_done,
  output ppu_pkg::ppu_time_t ptime
);
  import ppu_pkg::*;

  logic [8:0] dot;
  logic [7:0] ly;
  logic [7:0] ly_next;
  ppu_mode_t  mode;
  logic       lcd_on;

  // LCDC bit 7 is the master enable
  assign lcd_on = regs.lcdc[7];

  // Line 153 wraps back to line 0
  assign ly_next = (ly == 8'(`FRAME_LINES - 1)) ? 8'd0 : ly + 8'd1;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot  <= '0;
      ly   <= '0;
      mode <= MODE_OAM;
    end else if (!lcd_on) begin
      // LCD off, park at line 0 dot 0
      dot  <= '0;
      ly   <= '0;
      mode <= MODE_OAM;
    end else if (dot == 9'(`LINE_DOTS - 1)) begin
      if (mode == MODE_DRAW && !line_done) begin
        // Late line_done, stretch the line at its last dot
        dot <= dot;
      end else begin
        dot  <= '0;
        ly   <= ly_next;
        mode <= (ly_next < 8'(`SCREEN_H)) ? MODE_OAM : MODE_VBLANK;
      end
    end else begin
      dot <= dot + 9'd1;
      case (mode)
        MODE_OAM: begin
          if (dot == 9'(`MODE2_DOTS - 1)) begin
            mode <= MODE_DRAW;
          end
        end
        MODE_DRAW: begin
          // Drawing length is set by the pixel stream
          if (line_done) begin
            mode <= MODE_HBLANK;
          end
        end
        default: begin
          // HBlank and VBlank run to the end of the line
          mode <= mode;
        end
      endcase
    end
  end

  assign ptime.mode = mode;
  assign ptime.ly   = ly;
  // Last OAM dot, drawing begins on the next one
  assign ptime.line_start  = lcd_on && mode == MODE_OAM && dot == 9'(`MODE2_DOTS - 1);
  assign ptime.frame_start = lcd_on && ly == 8'd0 && dot == 9'd0;

endmodule

// File: vram.sv
`include "ppu_cfg.svh"

module vram (
  input  logic               clk,
  input  logic               reset,
  input  logic               vram_wr_valid,
  output logic               vram_wr_ready,
  input  ppu_pkg::vram_wr_t  vram_wr,
  input  ppu_pkg::ppu_time_t ptime,
  input  logic               rd_req,
  input  logic [15:0]        rd_addr,
  output logic [7:0]         rd_data
);
  import ppu_pkg::*;

  logic [7:0]          mem [2**`VRAM_AW];
  logic [15:0]         rd_offset;

  // Host is locked out while the fetcher owns VRAM
  // Mode only reaches DRAW with the LCD on
  assign vram_wr_ready = (ptime.mode != MODE_DRAW);

  // Fetcher uses CPU addresses 0x8000..0x9FFF
  assign rd_offset = rd_addr - 16'h8000;

  always_ff @(posedge clk) begin
    if (vram_wr_valid && vram_wr_ready) begin
      mem[vram_wr.addr] <= vram_wr.data;
    end
  end

  // Registered read, data one cycle after the request
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_data <= '0;
    end else if (rd_req) begin
      rd_data <= mem[rd_offset[`VRAM_AW-1:0]];
    end
  end

endmodule

// File: bg_fetcher.sv
`include "ppu_cfg.svh"

module bg_fetcher (
  input  logic               clk,
  input  logic               reset,
  input  ppu_pkg::ppu_regs_t regs,
  input  ppu_pkg::ppu_time_t ptime,
  output logic               rd_req,
  output logic [15:0]        rd_addr,
  input  logic [7:0]         rd_data,
  input  logic               fifo_empty,
  output logic               push,
  output ppu_pkg::tile_row_t push_row
);
  import ppu_pkg::*;

  fetch_state_t state;
  // Low on the request dot, high on the capture dot
  logic         phase;
  // Tile column on screen, one step per push
  logic [4:0]   col;
  logic [7:0]   window_line;
  // Window was visible on the line being drawn
  logic         win_seen;
  logic [7:0]   tile_index;
  logic [7:0]   tile_low;
  logic [7:0]   tile_high;
  logic         draw;

  logic signed [8:0] wx_s;
  logic [7:0]   wx_start;
  logic [4:0]   win_start_tile;
  logic         window_visible;
  logic         window_active;
  logic [4:0]   map_x;
  logic [7:0]   map_y;
  logic [15:0]  map_base;
  logic [15:0]  map_addr;
  logic [15:0]  data_addr;

  assign draw = (ptime.mode == MODE_DRAW);

  // Window left edge is WX - 7, clamped at 0
  assign wx_s     = $signed({1'b0, regs.wx}) - 9'sd7;
  assign wx_start = wx_s[8] ? 8'd0 : wx_s[7:0];
  // First window tile column, rounded up
  assign win_start_tile = 5'((9'(wx_start) + 9'd7) >> 3);

  assign window_visible = regs.lcdc[5] && (ptime.ly >= regs.wy)
                          && (wx_s < $signed(9'(`SCREEN_W)));
  // Switch to window at tile granularity
  assign window_active = window_visible && ({col, 3'b000} >= wx_start);

  // Bit 6 picks the window map, bit 3 the background map
  always_comb begin
    if (window_active) begin
      map_base = regs.lcdc[6] ? 16'h9C00 : 16'h9800;
      map_x    = col - win_start_tile;
      map_y    = window_line;
    end else begin
      map_base = regs.lcdc[3] ? 16'h9C00 : 16'h9800;
      map_x    = regs.scx[7:3] + col;
      map_y    = regs.scy + ptime.ly;
    end
  end

  // 32 entries per map row
  assign map_addr = map_base + {6'b0, map_y[7:3], 5'b0} + {11'b0, map_x};

  // 16 bytes per tile, 2 bytes per row
  // LCDC bit 4 clear means signed index around 0x9000
  assign data_addr = regs.lcdc[4]
                     ? 16'h8000 + {4'b0, tile_index, 4'b0} + {12'b0, map_y[2:0], 1'b0}
                     : 16'h9000 + {{4{tile_index[7]}}, tile_index, 4'b0}
                       + {12'b0, map_y[2:0], 1'b0};

  // Request dot of each fetch step
  assign rd_req = draw && (state != FETCH_PUSH) && !phase;

  always_comb begin
    case (state)
      FETCH_TILE: rd_addr = map_addr;
      FETCH_LOW:  rd_addr = data_addr;
      FETCH_HIGH: rd_addr = data_addr + 16'd1;
      default:    rd_addr = map_addr;
    endcase
  end

  // FIFO takes a row only when it is empty
  assign push          = draw && (state == FETCH_PUSH) && fifo_empty;
  assign push_row.low  = tile_low;
  assign push_row.high = tile_high;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= FETCH_TILE;
      phase       <= 1'b0;
      col         <= '0;
      window_line <= '0;
      win_seen    <= 1'b0;
    end else begin
      // Window line restarts every frame
      if (ptime.frame_start) begin
        window_line <= '0;
        win_seen    <= 1'b0;
      end else if (ptime.line_start) begin
        // Count the previous line, then sample this one
        window_line <= window_line + {7'b0, win_seen};
        win_seen    <= window_visible;
      end

      if (ptime.line_start) begin
        state <= FETCH_TILE;
        phase <= 1'b0;
        col   <= '0;
      end else if (draw) begin
        case (state)
          FETCH_TILE, FETCH_LOW, FETCH_HIGH: begin
            phase <= ~phase;
            if (phase) begin
              state <= fetch_state_t'(state + 2'd1);
            end
          end
          default: begin
            // Back-pressure holds us here
            if (fifo_empty) begin
              state <= FETCH_TILE;
              col   <= col + 5'd1;
            end
          end
        endcase
      end
    end
  end

  // Capture dot latches the VRAM byte
  always_ff @(posedge clk) begin
    if (draw && phase) begin
      case (state)
        FETCH_TILE: tile_index <= rd_data;
        FETCH_LOW:  tile_low   <= rd_data;
        FETCH_HIGH: tile_high  <= rd_data;
        default:    tile_index <= tile_index;
      endcase
    end
  end

endmodule

// File: pixel_fifo.sv
`include "ppu_cfg.svh"

module pixel_fifo (
  input  logic               clk,
  input  logic               reset,
  input  logic               push,
  input  ppu_pkg::tile_row_t push_row,
  output logic               fifo_empty,
  input  logic [7:0]         ly,
  output logic               pix_valid,
  input  logic               pix_ready,
  output ppu_pkg::pixel_t    pix,
  output logic               line_done
);
  import ppu_pkg::*;

  tile_row_t  row_q;
  // Pixels left in the row
  logic [3:0] left;
  logic [7:0] x;
  logic [7:0] ly_q;
  // All 160 pixels of this line are out
  logic       line_full;
  logic       fire;

  assign fifo_empty = (left == 4'd0);
  assign pix_valid  = !fifo_empty;
  assign fire       = pix_valid && pix_ready;
  assign line_done  = fire && (x == 8'(`SCREEN_W - 1));

  // MSB first, high plane is the upper color bit
  assign pix.color = {row_q.high[7], row_q.low[7]};
  assign pix.x     = x;
  assign pix.y     = ly;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      left      <= '0;
      x         <= '0;
      ly_q      <= '0;
      line_full <= 1'b0;
    end else if (ly != ly_q) begin
      // New line, start counting again
      ly_q      <= ly;
      left      <= '0;
      x         <= '0;
      line_full <= 1'b0;
    end else if (fire) begin
      left <= left - 4'd1;
      x    <= line_done ? 8'd0 : x + 8'd1;
      if (line_done) begin
        line_full <= 1'b1;
      end
    end else if (push && fifo_empty && !line_full) begin
      left <= 4'd8;
    end
  end

  // Row shifts left as pixels leave
  always_ff @(posedge clk) begin
    if (fire) begin
      row_q.low  <= {row_q.low[6:0], 1'b0};
      row_q.high <= {row_q.high[6:0], 1'b0};
    end else if (push && fifo_empty) begin
      row_q <= push_row;
    end
  end

endmodule

// File: ppu_top.sv
module ppu_top (
  input  logic              clk,
  input  logic              reset,
  // Host register port
  input  logic              reg_wr_valid,
  input  ppu_pkg::reg_wr_t  reg_wr,
  // Host VRAM port
  input  logic              vram_wr_valid,
  output logic              vram_wr_ready,
  input  ppu_pkg::vram_wr_t vram_wr,
  // Pixel stream
  output logic              pix_valid,
  input  logic              pix_ready,
  output ppu_pkg::pixel_t   pix
);
  import ppu_pkg::*;

  ppu_regs_t   regs;
  ppu_time_t   ptime;
  logic        line_done;
  logic        rd_req;
  logic [15:0] rd_addr;
  logic [7:0]  rd_data;
  logic        fifo_empty;
  logic        push;
  tile_row_t   push_row;

  ppu_regs u_regs (
    .clk          (clk),
    .reset        (reset),
    .reg_wr_valid (reg_wr_valid),
    .reg_wr       (reg_wr),
    .regs         (regs)
  );

  // Line end comes back from the pixel FIFO
  ppu_timing u_timing (
    .clk       (clk),
    .reset     (reset),
    .regs      (regs),
    .line_done (line_done),
    .ptime     (ptime)
  );

  vram u_vram (
    .clk           (clk),
    .reset         (reset),
    .vram_wr_valid (vram_wr_valid),
    .vram_wr_ready (vram_wr_ready),
    .vram_wr       (vram_wr),
    .ptime         (ptime),
    .rd_req        (rd_req),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data)
  );

  bg_fetcher u_fetcher (
    .clk        (clk),
    .reset      (reset),
    .regs       (regs),
    .ptime      (ptime),
    .rd_req     (rd_req),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .fifo_empty (fifo_empty),
    .push       (push),
    .push_row   (push_row)
  );

  pixel_fifo u_fifo (
    .clk        (clk),
    .reset      (reset),
    .push       (push),
    .push_row   (push_row),
    .fifo_empty (fifo_empty),
    .ly         (ptime.ly),
    .pix_valid  (pix_valid),
    .pix_ready  (pix_ready),
    .pix        (pix),
    .line_done  (line_done)
  );

endmodule

// File: tb_ppu.sv
`include "ppu_cfg.svh"

module tb_ppu;
  import ppu_pkg::*;

  // Watchdog budget built from the frames the tests run
  localparam int FRAME_CYCLES  = `LINE_DOTS * `FRAME_LINES;
  localparam int LOAD_CYCLES   = 2 ** `VRAM_AW;
  localparam int FRAMES_RUN    = 6;
  // Room for lines stretched by random pix_ready
  localparam int MARGIN        = 4;
  localparam int WATCHDOG_TIME = (FRAMES_RUN * FRAME_CYCLES + LOAD_CYCLES) * MARGIN * 100;

  logic     clk;
  logic     reset;
  logic     reg_wr_valid;
  reg_wr_t  reg_wr;
  logic     vram_wr_valid;
  logic     vram_wr_ready;
  vram_wr_t vram_wr;
  logic     pix_valid;
  logic     pix_ready;
  pixel_t   pix;

  integer   seed;
  string    test_name;
  int       error_count;

  // Reference copies of VRAM and the registers
  logic [7:0] model_vram [2**`VRAM_AW];
  logic [7:0] m_lcdc;
  logic [7:0] m_scy;
  logic [7:0] m_scx;
  logic [7:0] m_wy;
  logic [7:0] m_wx;

  // Raster position of the next expected pixel
  int       exp_x;
  int       exp_y;
  int       win_line;
  int       frames_done;

  // Stimulus modes and host write bookkeeping
  logic     random_ready;
  logic     host_traffic;
  logic     wr_accepted;
  int       writes_done;
  int       writes_blocked;

  ppu_top uut (
    .clk           (clk),
    .reset         (reset),
    .reg_wr_valid  (reg_wr_valid),
    .reg_wr        (reg_wr),
    .vram_wr_valid (vram_wr_valid),
    .vram_wr_ready (vram_wr_ready),
    .vram_wr       (vram_wr),
    .pix_valid     (pix_valid),
    .pix_ready     (pix_ready),
    .pix           (pix)
  );

  always #50 clk = ~clk;

  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog expired before all frames came out of the pixel stream");
    $display("FAIL: see errors above");
    $fatal(1, "timeout");
  end

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("mismatch %s expected %0d actual %0d", name, expected, actual);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
    end
  endtask

  // Window shows on a line once LY reaches WY and WX-7 is on screen
  function automatic logic window_on_line(input int py);
    return m_lcdc[5] && py >= int'(m_wy) && int'(m_wx) - 7 < `SCREEN_W;
  endfunction

  function automatic logic [1:0] expected_color(input int px, input int py);
    int         col;
    int         wx_left;
    int         map_col;
    int         map_row;
    int         map_base;
    int         tile;
    int         addr;
    logic [2:0] bit_sel;
    col     = px / 8;
    wx_left = int'(m_wx) - 7;
    if (wx_left < 0) begin
      wx_left = 0;
    end
    if (window_on_line(py) && col * 8 >= wx_left) begin
      // Window columns count from the first covered tile
      map_col  = col - (wx_left + 7) / 8;
      map_row  = win_line;
      map_base = m_lcdc[6] ? 'h1C00 : 'h1800;
    end else begin
      map_col  = (int'(m_scx) / 8 + col) % 32;
      map_row  = (int'(m_scy) + py) % 256;
      map_base = m_lcdc[3] ? 'h1C00 : 'h1800;
    end
    tile = int'(model_vram[13'(map_base + (map_row / 8) * 32 + map_col)]);
    // Offsets from 0x8000 with signed mode centered on 0x9000
    if (m_lcdc[4]) begin
      addr = tile * 16;
    end else begin
      addr = 'h1000 + (tile >= 128 ? tile - 256 : tile) * 16;
    end
    addr    = addr + (map_row % 8) * 2;
    bit_sel = 3'(7 - px % 8);
    return {model_vram[13'(addr + 1)][bit_sel], model_vram[13'(addr)][bit_sel]};
  endfunction

  task automatic write_reg(input reg_sel_t sel, input logic [7:0] data);
    @(negedge clk);
    reg_wr_valid = 1'b1;
    reg_wr.sel   = sel;
    reg_wr.data  = data;
    case (sel)
      REG_LCDC: m_lcdc = data;
      REG_SCY:  m_scy  = data;
      REG_SCX:  m_scx  = data;
      REG_WY:   m_wy   = data;
      default:  m_wx   = data;
    endcase
    @(negedge clk);
    reg_wr_valid = 1'b0;
  endtask

  // Turn the LCD off, load new registers and restart it at line 0
  task automatic restart_lcd(input logic [7:0] lcdc, input logic [7:0] scy,
                             input logic [7:0] scx, input logic [7:0] wy,
                             input logic [7:0] wx);
    write_reg(REG_LCDC, lcdc & 8'h7F);
    write_reg(REG_SCY, scy);
    write_reg(REG_SCX, scx);
    write_reg(REG_WY, wy);
    write_reg(REG_WX, wx);
    exp_x    = 0;
    exp_y    = 0;
    win_line = 0;
    write_reg(REG_LCDC, lcdc | 8'h80);
  endtask

  // Fill all of VRAM with one byte per handshake
  task automatic load_vram();
    logic [31:0] r;
    for (int i = 0; i < 2 ** `VRAM_AW; i++) begin
      r = next_rand();
      @(negedge clk);
      vram_wr_valid = 1'b1;
      vram_wr.addr  = 13'(i);
      vram_wr.data  = r[7:0];
      while (!vram_wr_ready) begin
        @(negedge clk);
      end
      model_vram[13'(i)] = r[7:0];
    end
    @(negedge clk);
    vram_wr_valid = 1'b0;
  endtask

  task automatic check_pixel();
    logic [1:0] want;
    check_eq({test_name, " x"}, 32'(exp_x), 32'(pix.x));
    check_eq({test_name, " y"}, 32'(exp_y), 32'(pix.y));
    want = expected_color(exp_x, exp_y);
    check_eq($sformatf("%s color at x=%0d y=%0d", test_name, exp_x, exp_y),
             32'(want), 32'(pix.color));
    exp_x++;
    if (exp_x == `SCREEN_W) begin
      exp_x = 0;
      // Window line only moves on lines that showed the window
      if (window_on_line(exp_y)) begin
        win_line++;
      end
      exp_y++;
      if (exp_y == `SCREEN_H) begin
        exp_y    = 0;
        win_line = 0;
        frames_done++;
      end
    end
  endtask

  // One clock of pixel sink and host VRAM traffic
  task automatic step_cycle();
    logic [31:0] r;
    logic [31:0] q;
    @(negedge clk);
    q         = next_rand();
    pix_ready = random_ready ? q[0] : 1'b1;
    // Host is locked out while pixels of this line are still to come
    if (pix_valid || exp_x != 0) begin
      check_eq({test_name, " vram_wr_ready while drawing"}, 32'd0, 32'(vram_wr_ready));
    end
    if (pix_valid && pix_ready) begin
      check_pixel();
    end
    if (wr_accepted) begin
      vram_wr_valid = 1'b0;
      wr_accepted   = 1'b0;
    end
    r = next_rand();
    if (host_traffic && !vram_wr_valid && r[2:0] == 3'd0) begin
      vram_wr_valid = 1'b1;
      // Half of the writes hit the tile maps
      vram_wr.addr  = r[31] ? {2'b11, r[13:3]} : r[15:3];
      vram_wr.data  = r[23:16];
    end
    if (vram_wr_valid) begin
      if (vram_wr_ready) begin
        model_vram[vram_wr.addr] = vram_wr.data;
        wr_accepted = 1'b1;
        writes_done++;
      end else begin
        writes_blocked++;
      end
    end
  endtask

  task automatic run_frames(input int count);
    int target;
    target = frames_done + count;
    while (frames_done < target) begin
      step_cycle();
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] s;
    seed           = 32'h4b4bd7f9;
    clk            = 1'b0;
    reset          = 1'b1;
    reg_wr_valid   = 1'b0;
    reg_wr.sel     = REG_LCDC;
    reg_wr.data    = 8'h00;
    vram_wr_valid  = 1'b0;
    vram_wr.addr   = '0;
    vram_wr.data   = 8'h00;
    pix_ready      = 1'b0;
    error_count    = 0;
    frames_done    = 0;
    exp_x          = 0;
    exp_y          = 0;
    win_line       = 0;
    random_ready   = 1'b0;
    host_traffic   = 1'b0;
    wr_accepted    = 1'b0;
    writes_done    = 0;
    writes_blocked = 0;
    m_lcdc         = 8'h00;
    m_scy          = 8'h00;
    m_scx          = 8'h00;
    m_wy           = 8'h00;
    m_wx           = 8'h00;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Background only with 0x8000 tile data
    test_name = "bg_unsigned";
    load_vram();
    r = next_rand();
    restart_lcd(8'h90 | (r[7:0] & 8'h4F), r[15:8], r[23:16], 8'h00, 8'h00);
    run_frames(1);

    // Signed tile data on the 0x9C00 map under random back-pressure
    test_name    = "signed_alt_map";
    random_ready = 1'b1;
    r = next_rand();
    restart_lcd(8'h88 | (r[7:0] & 8'h47), r[15:8], r[23:16], 8'h00, 8'h00);
    run_frames(1);

    // Window over the background for two frames so the line counter restarts
    test_name = "window";
    r = next_rand();
    s = next_rand();
    restart_lcd(8'hA0 | (r[7:0] & 8'h5F), r[15:8], r[23:16], 8'(s % 144),
                8'(7 + (r % 160)));
    run_frames(2);

    // Host writes race the fetcher
    test_name    = "vram_block";
    host_traffic = 1'b1;
    r = next_rand();
    restart_lcd(8'h90 | (r[7:0] & 8'h4F), r[15:8], r[23:16], 8'h00, 8'h00);
    run_frames(2);
    host_traffic = 1'b0;
    while (vram_wr_valid) begin
      step_cycle();
    end
    check_eq("vram_block accepted writes seen", 32'd1, 32'(writes_done > 0));
    check_eq("vram_block blocked writes seen", 32'd1, 32'(writes_blocked > 0));

    if (error_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1, "errors found");
    end
  end

endmodule

// File: src.f
+incdir+.
ppu_pkg.sv
ppu_regs.sv
ppu_timing.sv
vram.sv
bg_fetcher.sv
pixel_fifo.sv
ppu_top.sv
tb_ppu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the PPU testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_ppu -f src.f -o tb_ppu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_ppu_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "PASS: all tests"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
